/* dv/cache_patterns.txt */
F 060 13579bd0 0 00000000
F 064 13579bd1 0 00000000
F 068 13579bd2 0 00000000
F 06c 13579bd3 0 00000000
F 070 13579bd4 0 00000000
F 074 13579bd5 0 00000000
F 078 13579bd6 0 00000000
F 07c 13579bd7 0 00000000
R 060 00000000 0 13579bd0
R 064 00000000 0 13579bd1
R 068 00000000 0 13579bd2
R 06c 00000000 0 13579bd3
R 070 00000000 0 13579bd4
R 074 00000000 0 13579bd5
R 078 00000000 0 13579bd6
R 07c 00000000 0 13579bd7
W 064 ffeeddcc 5 00000000
R 064 00000000 0 13ee9bcc
F 0a0 2468ace0 0 00000000
F 0a4 2468ace1 0 00000000
F 0a8 2468ace2 0 00000000
F 0ac 2468ace3 0 00000000
F 0b0 2468ace4 0 00000000
F 0b4 2468ace5 0 00000000
F 0b8 2468ace6 0 00000000
F 0bc 2468ace7 0 00000000
C 0a8 11223344 c 00000000
R 0a8 00000000 0 1122ace2
R 0a4 00000000 0 2468ace1
R 064 00000000 0 13ee9bcc
R 068 00000000 0 13579bd2
R 07c 00000000 0 13579bd7

/* tb.f */
logic/cache_pkg.sv
logic/line_store.sv
logic/apb_access_ctrl.sv
logic/refill_loader.sv
logic/cache_data_top.sv
dv/cache_data_sva.sv
dv/cache_data_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= cache_data_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
SIM_BIN   ?= sim_$(TOP)

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o $(SIM_BIN)
	./$(OBJ_DIR)/$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

/* dv/cache_data_tb.sv */
`timescale 1ns/1ps

module cache_data_tb import cache_pkg::*; ();

  logic  clk;
  logic  reset;
  logic  psel;
  logic  penable;
  logic  pwrite;
  addr_t paddr;
  word_t pwdata;
  strb_t pstrb;
  word_t prdata;
  logic  pready;
  logic  fill_psel;
  logic  fill_penable;
  addr_t fill_paddr;
  word_t fill_pwdata;
  logic  fill_pready;

  // one entry per pattern line
  logic [7:0]  op_q[$];
  addr_t       addr_q[$];
  word_t       data_q[$];
  strb_t       strb_q[$];
  word_t       exp_q[$];
  int unsigned watchdog_cycles = 0;

  cache_data_top dut_i (
    .clk          (clk),
    .reset        (reset),
    .psel         (psel),
    .penable      (penable),
    .pwrite       (pwrite),
    .paddr        (paddr),
    .pwdata       (pwdata),
    .pstrb        (pstrb),
    .prdata       (prdata),
    .pready       (pready),
    .fill_psel    (fill_psel),
    .fill_penable (fill_penable),
    .fill_paddr   (fill_paddr),
    .fill_pwdata  (fill_pwdata),
    .fill_pready  (fill_pready)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;             // 20 ns period
  end

  initial begin
    wait (watchdog_cycles != 0);
    repeat (watchdog_cycles) @(posedge clk);
    $display("run timed out after %0d cycles before the patterns were done", watchdog_cycles);
    $display("Checks failed");
    $fatal(1, "watchdog expired");
  end

  task automatic check_word(input string name, input word_t actual, input word_t expected);
    if (actual !== expected) begin
      $display("[FAIL] %s: got 0x%h, expected 0x%h", name, actual, expected);
      $display("Checks failed");
      $fatal(1, "word mismatch");
    end
  endtask

  task automatic check_bit(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      $display("[FAIL] %s: got 0x%h, expected 0x%h", name, actual, expected);
      $display("Checks failed");
      $fatal(1, "bit mismatch");
    end
  endtask

  // cpu side transfer, sampled at the falling edge
  task automatic cpu_access(input logic wr, input addr_t a, input word_t d, input strb_t s,
                            output word_t rdata);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= a;
    pwdata  <= d;
    pstrb   <= s;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    while (!pready) begin
      @(negedge clk);                   // wait states from reads and refill collisions
    end
    rdata = prdata;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic fill_write(input addr_t a, input word_t d);
    @(posedge clk);
    fill_psel    <= 1'b1;
    fill_penable <= 1'b0;
    fill_paddr   <= a;
    fill_pwdata  <= d;
    @(posedge clk);
    fill_penable <= 1'b1;
    @(negedge clk);
    check_bit("fill_pready", fill_pready, 1'b1);   // no wait states on refill
    @(posedge clk);
    fill_psel    <= 1'b0;
    fill_penable <= 1'b0;
  endtask

  initial begin
    int         fd;
    int         i;
    logic [7:0] op_c;
    addr_t      a;
    word_t      d;
    strb_t      s;
    word_t      e;
    word_t      rdata;

    void'($urandom(32'hdcd1_303b));
    reset        <= 1'b1;
    psel         <= 1'b0;
    penable      <= 1'b0;
    pwrite       <= 1'b0;
    paddr        <= '0;
    pwdata       <= '0;
    pstrb        <= '0;
    fill_psel    <= 1'b0;
    fill_penable <= 1'b0;
    fill_paddr   <= '0;
    fill_pwdata  <= '0;

    fd = $fopen("dv/cache_patterns.txt", "r");
    if (fd == 0) begin
      $display("could not open the pattern file dv/cache_patterns.txt");
      $display("Checks failed");
      $fatal(1, "no stimulus");
    end
    while ($fscanf(fd, "%s %h %h %h %h", op_c, a, d, s, e) == 5) begin
      op_q.push_back(op_c);
      addr_q.push_back(a);
      data_q.push_back(d);
      strb_q.push_back(s);
      exp_q.push_back(e);
    end
    $fclose(fd);
    watchdog_cycles = 16 + 40 * (op_q.size() + 1);

    repeat (16) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_bit("pready", pready, 1'b0);
    check_bit("fill_pready", fill_pready, 1'b0);

    i = 0;
    while (i < op_q.size()) begin
      repeat ($urandom % 4) @(posedge clk);
      case (op_q[i])
        "F": begin
          if (i + 1 < op_q.size() && op_q[i + 1] == "C") begin
            // store setup lines up with the last refill access, so its access
            // phase meets the line write
            fork
              fill_write(addr_q[i], data_q[i]);
              begin
                @(posedge clk);
                cpu_access(1'b1, addr_q[i + 1], data_q[i + 1], strb_q[i + 1], rdata);
              end
            join
            i++;
          end else begin
            fill_write(addr_q[i], data_q[i]);
          end
        end
        "W": cpu_access(1'b1, addr_q[i], data_q[i], strb_q[i], rdata);
        "R": begin
          cpu_access(1'b0, addr_q[i], '0, '0, rdata);
          check_word("prdata", rdata, exp_q[i]);
        end
        default: begin
          $display("pattern line %0d has an unexpected op code %s", i + 1, op_q[i]);
          $display("Checks failed");
          $fatal(1, "bad pattern");
        end
      endcase
      i++;
    end

    if (op_q.size() == 0) begin
      $display("the pattern file held no operations");
      $display("Checks failed");
      $fatal(1, "empty pattern file");
    end else begin
      $display("All checks passed");
      $finish;
    end
  end

endmodule

/* dv/cache_data_sva.sv */
`timescale 1ns/1ps

module cache_data_sva (
  input logic clk,
  input logic reset,
  input logic psel,
  input logic penable,
  input logic pready,
  input logic line_wr,
  input logic wd_en,
  input logic rd_en
);

  // refill owns the store port in its cycle
  line_wr_excl: assert property (@(posedge clk) disable iff (reset)
    line_wr |-> !(wd_en || rd_en))
    else $error("store port used while a refill line write is in progress");

  pready_in_access: assert property (@(posedge clk) disable iff (reset)
    pready |-> (psel && penable))
    else $error("pready raised outside an access phase");

  line_wr_pulse: assert property (@(posedge clk) disable iff (reset)
    line_wr |=> !line_wr)
    else $error("line_wr held for more than one cycle");

endmodule

bind apb_access_ctrl cache_data_sva sva_i (
  .clk     (clk),
  .reset   (reset),
  .psel    (psel),
  .penable (penable),
  .pready  (pready),
  .line_wr (line_wr),
  .wd_en   (wd_en),
  .rd_en   (rd_en)
);

/* logic/cache_data_top.sv */
`timescale 1ns/1ps

module cache_data_top import cache_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  // cpu port
  input  logic  psel,
  input  logic  penable,
  input  logic  pwrite,
  input  addr_t paddr,
  input  word_t pwdata,
  input  strb_t pstrb,
  output word_t prdata,
  output logic  pready,
  // refill port, writes only
  input  logic  fill_psel,
  input  logic  fill_penable,
  input  addr_t fill_paddr,
  input  word_t fill_pwdata,
  output logic  fill_pready
);

  logic      line_wr;
  line_idx_t line_wr_idx;
  line_t     line_wr_data;

  logic      rd_en;
  line_idx_t rd_idx;
  word_off_t rd_off;
  word_t     rd_word;
  logic      wd_en;
  line_idx_t wd_idx;
  word_off_t wd_off;
  word_t     wd_data;
  strb_t     wd_strb;

  refill_loader loader_i (
    .clk          (clk),
    .reset        (reset),
    .fill_psel    (fill_psel),
    .fill_penable (fill_penable),
    .fill_paddr   (fill_paddr),
    .fill_pwdata  (fill_pwdata),
    .fill_pready  (fill_pready),
    .line_wr      (line_wr),
    .line_wr_idx  (line_wr_idx),
    .line_wr_data (line_wr_data)
  );

  line_store store_i (
    .clk          (clk),
    .line_wr      (line_wr),
    .line_wr_idx  (line_wr_idx),
    .line_wr_data (line_wr_data),
    .rd_en        (rd_en),
    .rd_idx       (rd_idx),
    .rd_off       (rd_off),
    .wd_en        (wd_en),
    .wd_idx       (wd_idx),
    .wd_off       (wd_off),
    .wd_data      (wd_data),
    .wd_strb      (wd_strb),
    .rd_word      (rd_word)
  );

  apb_access_ctrl ctrl_i (
    .clk     (clk),
    .reset   (reset),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .pstrb   (pstrb),
    .line_wr (line_wr),
    .rd_word (rd_word),
    .pready  (pready),
    .prdata  (prdata),
    .rd_en   (rd_en),
    .rd_idx  (rd_idx),
    .rd_off  (rd_off),
    .wd_en   (wd_en),
    .wd_idx  (wd_idx),
    .wd_off  (wd_off),
    .wd_data (wd_data),
    .wd_strb (wd_strb)
  );

endmodule

/* logic/refill_loader.sv */
`timescale 1ns/1ps

module refill_loader import cache_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      fill_psel,
  input  logic      fill_penable,
  input  addr_t     fill_paddr,
  input  word_t     fill_pwdata,
  output logic      fill_pready,
  output logic      line_wr,
  output line_idx_t line_wr_idx,
  output line_t     line_wr_data
);

  line_t     asm_line;             // assembly register
  word_off_t fill_off;
  logic      fill_done;
  logic      last_word;

  // no wait states on the refill side
  assign fill_pready = fill_psel && fill_penable;
  assign fill_done   = fill_psel && fill_penable && fill_pready;

  assign fill_off  = fill_paddr[OFF_LSB +: OFF_BITS];
  assign last_word = fill_done && (fill_off == word_off_t'(LINE_WORDS - 1));

  // each word lands in its slot
  always_ff @(posedge clk) begin
    if (fill_done) begin
      asm_line[fill_off*WORD_BITS +: WORD_BITS] <= fill_pwdata;
    end
  end

  always_ff @(posedge clk) begin
    if (last_word) begin
      line_wr_idx <= fill_paddr[IDX_LSB +: IDX_BITS];
    end
  end

  // one cycle pulse after the last word
  always_ff @(posedge clk) begin
    if (reset) begin
      line_wr <= 1'b0;
    end else begin
      line_wr <= last_word;
    end
  end

  // the next word needs a setup cycle, so the line is stable here
  assign line_wr_data = asm_line;

endmodule

/* logic/apb_access_ctrl.sv */
`timescale 1ns/1ps

module apb_access_ctrl import cache_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      psel,
  input  logic      penable,
  input  logic      pwrite,
  input  addr_t     paddr,
  input  word_t     pwdata,
  input  strb_t     pstrb,
  input  logic      line_wr,       // store port taken by refill
  input  word_t     rd_word,
  output logic      pready,
  output word_t     prdata,
  output logic      rd_en,
  output line_idx_t rd_idx,
  output word_off_t rd_off,
  output logic      wd_en,
  output line_idx_t wd_idx,
  output word_off_t wd_off,
  output word_t     wd_data,
  output strb_t     wd_strb
);

  acc_state_t state, state_nxt;
  logic       setup_ph;
  logic       access_ph;

  assign setup_ph  = psel && !penable;
  assign access_ph = psel && penable;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= acc_idle;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    rd_en     = 1'b0;
    wd_en     = 1'b0;
    pready    = 1'b0;
    case (state)
      acc_idle: begin
        if (setup_ph && !pwrite) begin
          state_nxt = acc_read;                  // read goes through the store
        end else if (access_ph && pwrite && !line_wr) begin
          wd_en  = 1'b1;                         // single cycle store
          pready = 1'b1;
        end
      end
      acc_read: begin
        if (access_ph && !line_wr) begin
          rd_en     = 1'b1;
          state_nxt = acc_done;
        end
      end
      acc_done: begin
        pready    = 1'b1;                        // registered word is ready
        state_nxt = acc_idle;
      end
      default: state_nxt = acc_idle;
    endcase
  end

  assign prdata = (state == acc_done) ? rd_word : '0;

  // address split for both store ports
  assign rd_idx  = paddr[IDX_LSB +: IDX_BITS];
  assign rd_off  = paddr[OFF_LSB +: OFF_BITS];
  assign wd_idx  = paddr[IDX_LSB +: IDX_BITS];
  assign wd_off  = paddr[OFF_LSB +: OFF_BITS];
  assign wd_data = pwdata;
  assign wd_strb = pstrb;

endmodule

/* logic/line_store.sv */
`timescale 1ns/1ps

module line_store import cache_pkg::*; (
  input  logic      clk,
  input  logic      line_wr,       // refill line write
  input  line_idx_t line_wr_idx,
  input  line_t     line_wr_data,
  input  logic      rd_en,
  input  line_idx_t rd_idx,
  input  word_off_t rd_off,
  input  logic      wd_en,         // cpu word store
  input  line_idx_t wd_idx,
  input  word_off_t wd_off,
  input  word_t     wd_data,
  input  strb_t     wd_strb,
  output word_t     rd_word
);

  logic [LINE_BYTES-1:0] word_be;    // store strobes placed in line
  logic [LINE_BYTES-1:0] wr_be;
  line_t                 wr_line;
  line_idx_t             wr_idx;

  logic [BANK_BITS-1:0]  bank_q [BANK_COUNT];
  line_t                 line_q;
  word_off_t             off_q;
  logic [LINE_WORDS-1:0] off_hot;

  // expand the word strobes into the line byte enables
  always_comb begin
    word_be = '0;
    for (int w = 0; w < LINE_WORDS; w++) begin
      if (wd_en && (wd_off == word_off_t'(w))) begin
        word_be[w*BYTES_PER_WORD +: BYTES_PER_WORD] = wd_strb;
      end
    end
  end

  // refill takes the write port over the store
  assign wr_be   = line_wr ? {LINE_BYTES{1'b1}} : word_be;
  assign wr_line = line_wr ? line_wr_data : {LINE_WORDS{wd_data}};   // word in every slot
  assign wr_idx  = line_wr ? line_wr_idx : wd_idx;

  for (genvar b = 0; b < BANK_COUNT; b++) begin : g_bank
    logic [BANK_BITS-1:0] mem [LINE_COUNT];

    always_ff @(posedge clk) begin
      for (int j = 0; j < BANK_BYTES; j++) begin
        if (wr_be[b*BANK_BYTES + j]) begin
          mem[wr_idx][j*8 +: 8] <= wr_line[b*BANK_BITS + j*8 +: 8];
        end
      end
      if (rd_en) begin
        bank_q[b] <= mem[rd_idx];          // one cycle read
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      off_q <= rd_off;                     // kept with the line
    end
  end

  always_comb begin
    for (int b = 0; b < BANK_COUNT; b++) begin
      line_q[b*BANK_BITS +: BANK_BITS] = bank_q[b];
    end
  end

  // one-hot word select from the registered line
  always_comb begin
    off_hot = '0;
    off_hot[off_q] = 1'b1;
    rd_word = '0;
    for (int w = 0; w < LINE_WORDS; w++) begin
      rd_word = rd_word | ({WORD_BITS{off_hot[w]}} & line_q[w*WORD_BITS +: WORD_BITS]);
    end
  end

endmodule

/* logic/cache_pkg.sv */
package cache_pkg;

  // cache geometry
  localparam int WORD_BITS  = 32;
  localparam int LINE_WORDS = 8;
  localparam int LINE_COUNT = 128;
  localparam int ADDR_BITS  = 12;

  localparam int LINE_BITS      = WORD_BITS * LINE_WORDS;   // 256
  localparam int BYTES_PER_WORD = WORD_BITS / 8;
  localparam int LINE_BYTES     = BYTES_PER_WORD * LINE_WORDS;

  localparam int BANK_COUNT = 4;
  localparam int BANK_BITS  = LINE_BITS / BANK_COUNT;        // 64 bits per bank
  localparam int BANK_BYTES = BANK_BITS / 8;

  // byte address split into index, offset and byte
  localparam int OFF_BITS = $clog2(LINE_WORDS);
  localparam int IDX_BITS = $clog2(LINE_COUNT);
  localparam int OFF_LSB  = $clog2(BYTES_PER_WORD);          // bits 1:0 ignored
  localparam int IDX_LSB  = OFF_LSB + OFF_BITS;

  typedef logic [WORD_BITS-1:0]      word_t;
  typedef logic [LINE_BITS-1:0]      line_t;       // word 0 in low bits
  typedef logic [ADDR_BITS-1:0]      addr_t;
  typedef logic [IDX_BITS-1:0]       line_idx_t;
  typedef logic [OFF_BITS-1:0]       word_off_t;
  typedef logic [BYTES_PER_WORD-1:0] strb_t;

  typedef enum logic [1:0] {
    acc_idle,
    acc_read,
    acc_done
  } acc_state_t;

endpackage
